//--- hw/nn_settings.svh
`ifndef NN_SETTINGS_SVH
`define NN_SETTINGS_SVH

// Q8.8 word for activations and weights
`define NN_DATA_W 16
`define NN_FRAC_W 8

// nodes per layer: input, hidden 1, hidden 2, output
`define NN_NODES_L0 2
`define NN_NODES_L1 4
`define NN_NODES_L2 4
`define NN_NODES_L3 3

`define NN_NODE_W 2 // fits the widest layer
`define NN_LAYER_W 2

// host bus
`define NN_AXI_ADDR_W 12
`define NN_AXI_DATA_W 32

`endif

//--- hw/nn_pkg.sv
`include "nn_settings.svh"

package nn_pkg;

	// one access to either memory
	typedef struct packed {
		logic en;
		logic wr; // 1 for write
		logic is_weight;
		logic [`NN_LAYER_W-1:0] layer; // bank, or source layer for weights
		logic [`NN_NODE_W-1:0] dst;
		logic [`NN_NODE_W-1:0] src; // weights only
		logic [`NN_DATA_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic start; // single cycle
		logic [`NN_LAYER_W-1:0] src_layer;
	} eng_ctrl_t;

	typedef struct packed {
		logic region; // 0 here
		logic [`NN_AXI_ADDR_W-4:0] index;
		logic [1:0] byte_ofs;
	} reg_view_t;

	typedef struct packed {
		logic region; // 1 here
		logic [`NN_AXI_ADDR_W-5-`NN_LAYER_W-2*`NN_NODE_W:0] pad; // must be zero
		logic is_weight;
		logic [`NN_LAYER_W-1:0] layer;
		logic [`NN_NODE_W-1:0] dst;
		logic [`NN_NODE_W-1:0] src;
		logic [1:0] byte_ofs;
	} mem_view_t;

	// host address word, register space or memory window
	typedef union packed {
		reg_view_t reg_view;
		mem_view_t mem_view;
	} axil_addr_u;

endpackage

//--- hw/nn_act_ram.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module nn_act_ram (
	input  logic clk,
	input  logic i_reset,
	input  nn_pkg::mem_req_t i_req,
	output logic [`NN_DATA_W-1:0] o_rdata,
	output logic o_rvalid
);
	localparam int L0_AW = $clog2(`NN_NODES_L0);
	localparam int L1_AW = $clog2(`NN_NODES_L1);
	localparam int L2_AW = $clog2(`NN_NODES_L2);
	localparam int L3_AW = $clog2(`NN_NODES_L3);

	logic [`NN_DATA_W-1:0] bank_l0 [`NN_NODES_L0]; // input layer
	logic [`NN_DATA_W-1:0] bank_l1 [`NN_NODES_L1];
	logic [`NN_DATA_W-1:0] bank_l2 [`NN_NODES_L2];
	logic [`NN_DATA_W-1:0] bank_l3 [`NN_NODES_L3]; // output layer

	always_ff @(posedge clk) begin
		if (i_req.en && i_req.wr && !i_req.is_weight) begin
			case (i_req.layer)
				2'd0: bank_l0[i_req.dst[L0_AW-1:0]] <= i_req.wdata;
				2'd1: bank_l1[i_req.dst[L1_AW-1:0]] <= i_req.wdata;
				2'd2: bank_l2[i_req.dst[L2_AW-1:0]] <= i_req.wdata;
				default: bank_l3[i_req.dst[L3_AW-1:0]] <= i_req.wdata;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_req.en && !i_req.wr) begin
			case (i_req.layer)
				2'd0: o_rdata <= bank_l0[i_req.dst[L0_AW-1:0]];
				2'd1: o_rdata <= bank_l1[i_req.dst[L1_AW-1:0]];
				2'd2: o_rdata <= bank_l2[i_req.dst[L2_AW-1:0]];
				default: o_rdata <= bank_l3[i_req.dst[L3_AW-1:0]];
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_rvalid <= 1'b0;
		end else begin
			o_rvalid <= i_req.en && !i_req.wr; // only the cycle after a read
		end
	end
endmodule

//--- hw/nn_weight_ram.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module nn_weight_ram (
	input  logic clk,
	input  logic i_reset,
	input  nn_pkg::mem_req_t i_req,
	output logic [`NN_DATA_W-1:0] o_rdata,
	output logic o_rvalid
);
	localparam int N_TRANS = 3; // l0->l1, l1->l2, l2->l3
	localparam int N_NODE = 1 << `NN_NODE_W;
	localparam int DEPTH = N_TRANS * N_NODE * N_NODE;
	localparam int ADDR_W = `NN_LAYER_W + 2 * `NN_NODE_W;

	logic [`NN_DATA_W-1:0] mem [DEPTH];
	logic [ADDR_W-1:0] addr;

	// transition major, then destination, then source
	assign addr = {i_req.layer, i_req.dst, i_req.src};

	always_ff @(posedge clk) begin
		if (i_req.en && i_req.wr && i_req.is_weight) begin
			mem[addr] <= i_req.wdata;
		end
		if (i_req.en && !i_req.wr) begin
			o_rdata <= mem[addr];
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_rvalid <= 1'b0;
		end else begin
			o_rvalid <= i_req.en && !i_req.wr;
		end
	end
endmodule

//--- hw/nn_layer_engine.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module nn_layer_engine (
	input  logic clk,
	input  logic i_reset,
	input  nn_pkg::eng_ctrl_t i_ctrl,
	input  nn_pkg::mem_req_t i_host_req,
	output logic o_host_grant,
	output logic [`NN_DATA_W-1:0] o_host_rdata,
	output logic o_host_rvalid,
	output nn_pkg::mem_req_t o_act_req,
	output nn_pkg::mem_req_t o_wgt_req,
	input  logic [`NN_DATA_W-1:0] i_act_rdata,
	input  logic i_act_rvalid,
	input  logic [`NN_DATA_W-1:0] i_wgt_rdata,
	input  logic i_wgt_rvalid,
	output logic o_busy,
	output logic o_done
);
	localparam int ACC_W = 2 * `NN_DATA_W;
	localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'((1 <<< (`NN_DATA_W - 1)) - 1);
	localparam logic signed [ACC_W-1:0] SAT_MIN = -SAT_MAX - 1;
	localparam logic [`NN_NODE_W-1:0] LAST_NODE [4] = '{
		`NN_NODE_W'(`NN_NODES_L0 - 1), `NN_NODE_W'(`NN_NODES_L1 - 1),
		`NN_NODE_W'(`NN_NODES_L2 - 1), `NN_NODE_W'(`NN_NODES_L3 - 1)};

	typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_DRAIN, S_WRITE} state_t;

	state_t state;
	logic [`NN_LAYER_W-1:0] layer_q; // source layer
	logic [`NN_NODE_W-1:0] dst_q;
	logic [`NN_NODE_W-1:0] src_q;
	logic [`NN_NODE_W-1:0] dst_last;
	logic [`NN_NODE_W-1:0] src_last;
	logic signed [ACC_W-1:0] product;
	logic signed [ACC_W-1:0] acc;
	logic signed [`NN_DATA_W-1:0] sat;
	logic [`NN_DATA_W-1:0] result;
	logic host_rd_q; // host read in flight
	logic host_wgt_q;

	assign o_host_grant = state == S_IDLE;
	assign o_busy = state != S_IDLE;
	assign o_done = state == S_WRITE && dst_q == dst_last; // last write of the layer
	assign o_host_rdata = host_wgt_q ? i_wgt_rdata : i_act_rdata;
	assign o_host_rvalid = host_rd_q && (host_wgt_q ? i_wgt_rvalid : i_act_rvalid);

	assign product = $signed(i_act_rdata) * $signed(i_wgt_rdata);

	always_comb begin
		if (acc > SAT_MAX) begin
			sat = SAT_MAX[`NN_DATA_W-1:0];
		end else if (acc < SAT_MIN) begin
			sat = SAT_MIN[`NN_DATA_W-1:0];
		end else begin
			sat = acc[`NN_DATA_W-1:0];
		end
	end

	assign result = sat[`NN_DATA_W-1] ? '0 : sat; // relu

	always_comb begin
		o_act_req = '0;
		o_wgt_req = '0;
		case (state)
			S_IDLE: begin // host owns both memories
				o_act_req = i_host_req;
				o_act_req.en = i_host_req.en && !i_host_req.is_weight;
				o_wgt_req = i_host_req;
				o_wgt_req.en = i_host_req.en && i_host_req.is_weight;
			end
			S_ISSUE: begin
				o_act_req.en = 1'b1;
				o_act_req.layer = layer_q;
				o_act_req.dst = src_q; // source activation
				o_wgt_req.en = 1'b1;
				o_wgt_req.is_weight = 1'b1;
				o_wgt_req.layer = layer_q;
				o_wgt_req.dst = dst_q;
				o_wgt_req.src = src_q;
			end
			S_WRITE: begin
				o_act_req.en = 1'b1;
				o_act_req.wr = 1'b1;
				o_act_req.layer = layer_q + 1'b1;
				o_act_req.dst = dst_q;
				o_act_req.wdata = result;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= S_IDLE;
			dst_q <= '0;
			src_q <= '0;
			host_rd_q <= 1'b0;
		end else begin
			host_rd_q <= o_host_grant && i_host_req.en && !i_host_req.wr;
			case (state)
				S_IDLE: begin
					if (i_ctrl.start) begin
						state <= S_ISSUE;
						dst_q <= '0;
						src_q <= '0;
					end
				end
				S_ISSUE: begin
					if (src_q == src_last) begin
						state <= S_DRAIN; // last product still in flight
						src_q <= '0;
					end else begin
						src_q <= src_q + 1'b1;
					end
				end
				S_DRAIN: state <= S_WRITE;
				default: begin
					if (dst_q == dst_last) begin
						state <= S_IDLE;
					end else begin
						state <= S_ISSUE;
						dst_q <= dst_q + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		host_wgt_q <= i_host_req.is_weight;
		if (state == S_IDLE && i_ctrl.start) begin
			layer_q <= i_ctrl.src_layer;
			src_last <= LAST_NODE[i_ctrl.src_layer];
			dst_last <= LAST_NODE[i_ctrl.src_layer + 1'b1];
		end
		// accumulate trails issue by one cycle
		if (state == S_IDLE || state == S_WRITE) begin
			acc <= '0;
		end else if (i_act_rvalid && i_wgt_rvalid) begin
			acc <= acc + (product >>> `NN_FRAC_W);
		end
	end
endmodule

//--- hw/nn_axil_regs.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module nn_axil_regs (
	input  logic clk,
	input  logic i_reset,
	input  logic [`NN_AXI_ADDR_W-1:0] i_awaddr,
	input  logic i_awvalid,
	output logic o_awready,
	input  logic [`NN_AXI_DATA_W-1:0] i_wdata,
	input  logic i_wvalid,
	output logic o_wready,
	output logic [1:0] o_bresp,
	output logic o_bvalid,
	input  logic i_bready,
	input  logic [`NN_AXI_ADDR_W-1:0] i_araddr,
	input  logic i_arvalid,
	output logic o_arready,
	output logic [`NN_AXI_DATA_W-1:0] o_rdata,
	output logic [1:0] o_rresp,
	output logic o_rvalid,
	input  logic i_rready,
	output nn_pkg::eng_ctrl_t o_ctrl,
	output nn_pkg::mem_req_t o_host_req,
	input  logic i_host_grant,
	input  logic [`NN_DATA_W-1:0] i_host_rdata,
	input  logic i_host_rvalid,
	input  logic i_busy,
	input  logic i_done
);
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam logic [`NN_AXI_ADDR_W-4:0] REG_CTRL = 0;
	localparam logic [`NN_AXI_ADDR_W-4:0] REG_STATUS = 1;
	localparam logic [`NN_LAYER_W-1:0] MAX_SRC = 2; // last layer with a successor

	typedef enum logic [2:0] {S_INIT, S_IDLE, S_WIN_RD, S_BRESP, S_RRESP} state_t;

	state_t state;
	nn_pkg::axil_addr_u wr_addr;
	nn_pkg::axil_addr_u rd_addr;
	nn_pkg::mem_view_t win;
	logic wr_fire;
	logic rd_fire;
	logic wr_win;
	logic rd_win;
	logic ctrl_sel;
	logic done_q; // sticky
	logic [`NN_LAYER_W-1:0] new_layer;

	assign wr_addr = i_awaddr;
	assign rd_addr = i_araddr;

	// AW and W only complete together
	assign o_awready = state == S_IDLE && i_wvalid;
	assign o_wready = state == S_IDLE && i_awvalid;
	assign o_arready = state == S_IDLE && !(i_awvalid && i_wvalid); // writes first
	assign wr_fire = state == S_IDLE && i_awvalid && i_wvalid;
	assign rd_fire = o_arready && i_arvalid;
	assign o_bvalid = state == S_BRESP;
	assign o_rvalid = state == S_RRESP;

	assign wr_win = wr_addr.mem_view.region && wr_addr.mem_view.pad == '0;
	assign rd_win = rd_addr.mem_view.region && rd_addr.mem_view.pad == '0;
	assign ctrl_sel = !wr_addr.reg_view.region && wr_addr.reg_view.index == REG_CTRL;
	assign new_layer = i_wdata[2:1];

	// window access goes out in the accept cycle
	always_comb begin
		win = wr_fire ? wr_addr.mem_view : rd_addr.mem_view;
		o_host_req.en = wr_fire ? wr_win : rd_fire && rd_win;
		o_host_req.wr = wr_fire;
		o_host_req.is_weight = win.is_weight;
		o_host_req.layer = win.layer;
		o_host_req.dst = win.dst;
		o_host_req.src = win.src;
		o_host_req.wdata = i_wdata[`NN_DATA_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= S_INIT;
			o_ctrl <= '0;
			done_q <= 1'b0;
		end else begin
			o_ctrl.start <= 1'b0;
			if (i_done) begin
				done_q <= 1'b1;
			end
			case (state)
				S_INIT: state <= S_IDLE;
				S_IDLE: begin
					if (wr_fire) begin
						state <= S_BRESP;
						if (ctrl_sel && i_wdata[0]) begin
							done_q <= 1'b0;
							if (new_layer <= MAX_SRC && !i_busy) begin
								o_ctrl.start <= 1'b1;
								o_ctrl.src_layer <= new_layer;
							end
						end
					end else if (rd_fire) begin
						state <= rd_win && i_host_grant ? S_WIN_RD : S_RRESP;
					end
				end
				S_WIN_RD: begin
					if (i_host_rvalid) begin
						state <= S_RRESP;
					end
				end
				S_BRESP: begin
					if (i_bready) begin
						state <= S_IDLE;
					end
				end
				S_RRESP: begin
					if (i_rready) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			if (wr_addr.reg_view.region) begin
				o_bresp <= wr_win && i_host_grant ? RESP_OKAY : RESP_SLVERR; // engine busy
			end else begin
				o_bresp <= ctrl_sel ? RESP_OKAY : RESP_SLVERR;
			end
		end
		if (rd_fire) begin
			o_rresp <= RESP_OKAY;
			o_rdata <= '0;
			if (rd_addr.reg_view.region) begin
				if (!(rd_win && i_host_grant)) begin
					o_rresp <= RESP_SLVERR;
				end
			end else begin
				case (rd_addr.reg_view.index)
					REG_CTRL: o_rdata <= {{(`NN_AXI_DATA_W-1-`NN_LAYER_W){1'b0}}, o_ctrl.src_layer, 1'b0};
					REG_STATUS: o_rdata <= {{(`NN_AXI_DATA_W-2){1'b0}}, done_q, i_busy};
					default: o_rresp <= RESP_SLVERR;
				endcase
			end
		end else if (state == S_WIN_RD && i_host_rvalid) begin
			o_rdata <= {{(`NN_AXI_DATA_W-`NN_DATA_W){i_host_rdata[`NN_DATA_W-1]}}, i_host_rdata};
		end
	end
endmodule

//--- hw/nn_top.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module nn_top (
	input  logic clk,
	input  logic i_reset,
	input  logic [`NN_AXI_ADDR_W-1:0] i_awaddr,
	input  logic i_awvalid,
	output logic o_awready,
	input  logic [`NN_AXI_DATA_W-1:0] i_wdata,
	input  logic i_wvalid,
	output logic o_wready,
	output logic [1:0] o_bresp,
	output logic o_bvalid,
	input  logic i_bready,
	input  logic [`NN_AXI_ADDR_W-1:0] i_araddr,
	input  logic i_arvalid,
	output logic o_arready,
	output logic [`NN_AXI_DATA_W-1:0] o_rdata,
	output logic [1:0] o_rresp,
	output logic o_rvalid,
	input  logic i_rready
);
	nn_pkg::eng_ctrl_t eng_ctrl;
	nn_pkg::mem_req_t host_req;
	nn_pkg::mem_req_t act_req;
	nn_pkg::mem_req_t wgt_req;
	logic host_grant;
	logic [`NN_DATA_W-1:0] host_rdata;
	logic host_rvalid;
	logic [`NN_DATA_W-1:0] act_rdata;
	logic act_rvalid;
	logic [`NN_DATA_W-1:0] wgt_rdata;
	logic wgt_rvalid;
	logic busy;
	logic done;

	// bus ports share names with the top
	nn_axil_regs i_regs (
		.*,
		.o_ctrl(eng_ctrl),
		.o_host_req(host_req), .i_host_grant(host_grant),
		.i_host_rdata(host_rdata), .i_host_rvalid(host_rvalid),
		.i_busy(busy), .i_done(done)
	);

	nn_layer_engine i_engine (
		.clk(clk), .i_reset(i_reset),
		.i_ctrl(eng_ctrl),
		.i_host_req(host_req), .o_host_grant(host_grant),
		.o_host_rdata(host_rdata), .o_host_rvalid(host_rvalid),
		.o_act_req(act_req), .o_wgt_req(wgt_req),
		.i_act_rdata(act_rdata), .i_act_rvalid(act_rvalid),
		.i_wgt_rdata(wgt_rdata), .i_wgt_rvalid(wgt_rvalid),
		.o_busy(busy), .o_done(done)
	);

	nn_act_ram i_act_ram (
		.clk(clk), .i_reset(i_reset), .i_req(act_req),
		.o_rdata(act_rdata), .o_rvalid(act_rvalid)
	);

	nn_weight_ram i_weight_ram (
		.clk(clk), .i_reset(i_reset), .i_req(wgt_req),
		.o_rdata(wgt_rdata), .o_rvalid(wgt_rvalid)
	);
endmodule

//--- test/nn_tb.sv
`timescale 1ns/1ps
`include "nn_settings.svh"

module nn_tb;
	localparam int N_CASES = 3;
	localparam int WATCHDOG_CYCLES = N_CASES * 3 * 4 * 6 + 2000;
	localparam logic [11:0] ADDR_CTRL = 12'h000;
	localparam logic [11:0] ADDR_STATUS = 12'h004;
	localparam logic [11:0] ADDR_UNMAPPED = 12'h008;
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	typedef struct packed {
		logic [0:1][15:0] act_in; // input layer, Q8.8
		logic [0:2][15:0] w_base; // per transition
		logic [0:2][15:0] w_step; // added per (dst, src) slot
		logic busy_check;
	} case_t;

	case_t cases [N_CASES] = '{
		'{'{16'h0100, 16'hff80}, '{16'hff00, 16'hffc0, 16'h0080},
			'{16'h0040, 16'h0030, 16'hffe0}, 1'b0}, // mixed signs, relu clips
		'{'{16'h4000, 16'h3000}, '{16'h4000, 16'h4000, 16'h4000},
			'{16'h0100, 16'h0100, 16'h0100}, 1'b0}, // overflows every layer
		'{'{16'h0080, 16'h0180}, '{16'h0040, 16'hff00, 16'h0020},
			'{16'h0010, 16'h0030, 16'hfff0}, 1'b1}
	};

	logic clk;
	logic i_reset;
	logic [`NN_AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`NN_AXI_DATA_W-1:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`NN_AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`NN_AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [15:0] model [4][4]; // expected activations per layer

	nn_top i_nn_top (
		.clk(clk), .i_reset(i_reset),
		.i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
		.i_wdata(wdata), .i_wvalid(wvalid), .o_wready(wready),
		.o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
		.i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
		.o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic int n_nodes(input int layer);
		case (layer)
			0: return `NN_NODES_L0;
			1: return `NN_NODES_L1;
			2: return `NN_NODES_L2;
			default: return `NN_NODES_L3;
		endcase
	endfunction

	function automatic logic [11:0] win_addr(input logic is_w, input int layer,
			input int dst, input int src);
		return 12'h800 | (12'(is_w) << 8) | (12'(layer) << 6) | (12'(dst) << 4) | (12'(src) << 2);
	endfunction

	function automatic logic [15:0] weight(input int c, input int t, input int d, input int s);
		return cases[c].w_base[t] + cases[c].w_step[t] * 16'(d * 4 + s);
	endfunction

	function automatic logic [31:0] sext(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// Q8.8 dot product, then saturate and relu
	function automatic logic [15:0] neuron(input int c, input int t, input int d);
		int s;
		int act;
		int wgt;
		int sum;
		sum = 0;
		for (s = 0; s < n_nodes(t); s++) begin
			act = $signed(model[t][s]);
			wgt = $signed(weight(c, t, d, s));
			sum += (act * wgt) >>> `NN_FRAC_W;
		end
		if (sum > 32767) begin
			sum = 32767;
		end else if (sum < -32768) begin
			sum = -32768;
		end
		if (sum < 0) begin
			sum = 0;
		end
		return 16'(sum);
	endfunction

	task automatic value_error(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else value_error($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do @(negedge clk); while (!(awready && wready));
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		do @(negedge clk); while (!bvalid);
		resp = bresp;
		repeat ($urandom % 3) @(posedge clk); // random back-pressure
		@(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		araddr <= addr;
		arvalid <= 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		do @(negedge clk); while (!rvalid);
		data = rdata;
		resp = rresp;
		repeat ($urandom % 3) @(posedge clk);
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic wait_idle(output logic [31:0] status);
		logic [1:0] resp;
		do begin
			axi_read(ADDR_STATUS, status, resp);
		end while (status[0]); // busy
	endtask

	task automatic store_or_verify(input logic [11:0] addr, input logic [15:0] value,
			input bit verify);
		logic [31:0] data;
		logic [1:0] resp;
		if (!verify) begin
			axi_write(addr, {16'ha5a5, value}, resp); // upper half must be dropped
			check_value(32'(resp), 32'(OKAY), $sformatf("write response at %h", addr));
		end else begin
			axi_read(addr, data, resp);
			check_value(32'(resp), 32'(OKAY), $sformatf("read response at %h", addr));
			check_value(data, sext(value), $sformatf("readback at %h", addr));
		end
	endtask

	task automatic load_case(input int c);
		int pass;
		int t;
		int d;
		int s;
		for (s = 0; s < n_nodes(0); s++) begin
			model[0][s] = cases[c].act_in[s];
		end
		for (pass = 0; pass < 2; pass++) begin // write all, then read all back
			for (s = 0; s < n_nodes(0); s++) begin
				store_or_verify(win_addr(1'b0, 0, s, 0), cases[c].act_in[s], pass == 1);
			end
			for (t = 0; t < 3; t++) begin
				for (d = 0; d < n_nodes(t + 1); d++) begin
					for (s = 0; s < n_nodes(t); s++) begin
						store_or_verify(win_addr(1'b1, t, d, s), weight(c, t, d, s), pass == 1);
					end
				end
			end
		end
	endtask

	task automatic run_layer(input int c, input int l);
		logic [31:0] data;
		logic [1:0] resp;
		int d;
		for (d = 0; d < n_nodes(l + 1); d++) begin
			model[l + 1][d] = neuron(c, l, d);
		end
		axi_write(ADDR_CTRL, 32'(1 | (l << 1)), resp);
		check_value(32'(resp), 32'(OKAY), "start response");
		if (cases[c].busy_check && l == 1) begin
			axi_write(win_addr(1'b1, 2, 0, 0), 32'h0000_1234, resp);
			check_value(32'(resp), 32'(SLVERR), "window write while busy");
			axi_read(win_addr(1'b0, 0, 0, 0), data, resp);
			check_value(32'(resp), 32'(SLVERR), "window read while busy");
		end
		wait_idle(data);
		check_value(data, 32'h2, $sformatf("status after layer %0d", l)); // done, not busy
		if (cases[c].busy_check && l == 1) begin
			axi_read(win_addr(1'b1, 2, 0, 0), data, resp);
			check_value(data, sext(weight(c, 2, 0, 0)), "weight after rejected write");
		end
		for (d = 0; d < n_nodes(l + 1); d++) begin
			axi_read(win_addr(1'b0, l + 1, d, 0), data, resp);
			check_value(32'(resp), 32'(OKAY), "result read response");
			check_value(data, sext(model[l + 1][d]),
				$sformatf("case %0d layer %0d node %0d", c, l + 1, d));
		end
	endtask

	initial begin
		logic [31:0] data;
		logic [1:0] resp;
		int c;
		int l;
		void'($urandom(32'ha1fa));
		i_reset <= 1'b1;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		repeat (16) @(posedge clk);
		i_reset <= 1'b0;
		@(negedge clk);
		check_value(32'(bvalid), 32'h0, "bvalid after reset");
		check_value(32'(rvalid), 32'h0, "rvalid after reset");
		check_value(32'(arready), 32'h0, "arready after reset");
		@(posedge clk);
		axi_read(ADDR_STATUS, data, resp);
		check_value(data, 32'h0, "status after reset");
		for (c = 0; c < N_CASES; c++) begin
			load_case(c);
			for (l = 0; l < 3; l++) begin
				run_layer(c, l);
			end
		end
		axi_read(ADDR_UNMAPPED, data, resp);
		check_value(32'(resp), 32'(SLVERR), "unmapped register read");
		axi_write(ADDR_CTRL, 32'h7, resp); // src_layer 3 has no successor
		axi_read(ADDR_STATUS, data, resp);
		check_value(data, 32'h0, "status after start with src_layer 3");
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$fatal(1);
	end
endmodule

//--- build.f
+incdir+hw
hw/nn_pkg.sv
hw/nn_act_ram.sv
hw/nn_weight_ram.sv
hw/nn_layer_engine.sv
hw/nn_axil_regs.sv
hw/nn_top.sv
test/nn_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module nn_tb -f build.f -o nn_sim
./obj_dir/nn_sim 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
echo "simulation passed"
